// ==== compile.f ====
src/ipv4_hdr_pkg.sv
src/chk_verify_pkg.sv
src/ipv4_word_sum.sv
src/ipv4_sum_fold.sv
src/ipv4_status_encode.sv
src/ipv4_checksum_verify.sv
verif/ipv4_checksum_verify_props.sv
verif/ipv4_checksum_verify_tb.sv

// ==== src/chk_verify_pkg.sv ====
/* Result codes and timing of the IPv4 header verifier.
   Shared by the output stage, the top level and the verification code */

package chk_verify_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Status codes
    ////////////////////////////////////////////////////////////////////////////

    // Listed in no particular order; priority is applied in the output stage
    typedef enum logic [1:0] {
        HDR_GOOD         = 2'd0,
        HDR_BAD_VERSION  = 2'd1,
        HDR_BAD_IHL      = 2'd2,
        HDR_BAD_CHECKSUM = 2'd3
    } chk_status_t;

    ////////////////////////////////////////////////////////////////////////////
    // Timing
    ////////////////////////////////////////////////////////////////////////////

    // Cycles from header_valid to result_valid, one per pipeline stage
    localparam int VERIFY_LATENCY = 3;

endpackage

// ==== src/ipv4_checksum_verify.sv ====
/* IPv4 header verifier: three-stage pipeline, one header per cycle in and one
   status per header out, three cycles after header_valid */

`timescale 1ns/100ps

module ipv4_checksum_verify
    import ipv4_hdr_pkg::*, chk_verify_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                header_valid,
    input  logic [HDR_BITS-1:0] header,
    output logic                result_valid,
    output chk_status_t         status,
    output logic                checksum_ok
);

    // Stage 1 to stage 2
    logic                    s1_valid;
    logic [PARTIAL_BITS-1:0] s1_sum_hi;
    logic [PARTIAL_BITS-1:0] s1_sum_lo;
    logic                    s1_version_bad;
    logic                    s1_ihl_bad;

    // Stage 2 to stage 3
    logic                    s2_valid;
    logic [WORD_BITS-1:0]    s2_sum;
    logic                    s2_version_bad;
    logic                    s2_ihl_bad;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////////////////////

    ipv4_word_sum u_word_sum (
        .clk            (clk),
        .reset          (reset),
        .header_valid   (header_valid),
        .header         (header),
        .s1_valid       (s1_valid),
        .s1_sum_hi      (s1_sum_hi),
        .s1_sum_lo      (s1_sum_lo),
        .s1_version_bad (s1_version_bad),
        .s1_ihl_bad     (s1_ihl_bad)
    );

    ipv4_sum_fold u_sum_fold (
        .clk            (clk),
        .reset          (reset),
        .s1_valid       (s1_valid),
        .s1_sum_hi      (s1_sum_hi),
        .s1_sum_lo      (s1_sum_lo),
        .s1_version_bad (s1_version_bad),
        .s1_ihl_bad     (s1_ihl_bad),
        .s2_valid       (s2_valid),
        .s2_sum         (s2_sum),
        .s2_version_bad (s2_version_bad),
        .s2_ihl_bad     (s2_ihl_bad)
    );

    ipv4_status_encode u_status_encode (
        .clk            (clk),
        .reset          (reset),
        .s2_valid       (s2_valid),
        .s2_sum         (s2_sum),
        .s2_version_bad (s2_version_bad),
        .s2_ihl_bad     (s2_ihl_bad),
        .result_valid   (result_valid),
        .status         (status),
        .checksum_ok    (checksum_ok)
    );

endmodule

// ==== src/ipv4_hdr_pkg.sv ====
/* IPv4 header layout for a 20-byte header carried as one 160-bit word.
   First transmitted byte sits in the top bits; import where fields are sliced */

package ipv4_hdr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Header geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int HDR_BITS  = 160;
    localparam int WORD_BITS = 16;
    localparam int HDR_WORDS = HDR_BITS / WORD_BITS;

    // Five 16-bit words summed without folding
    localparam int PARTIAL_BITS = 19;

    ////////////////////////////////////////////////////////////////////////////
    // Field positions in the 160-bit word
    ////////////////////////////////////////////////////////////////////////////

    // Version and IHL share the first byte
    localparam int VERSION_MSB = 159;
    localparam int VERSION_LSB = 156;
    localparam int IHL_MSB     = 155;
    localparam int IHL_LSB     = 152;

    // Checksum is bytes 10 and 11, i.e. word 5
    localparam int CHKSUM_MSB = 79;
    localparam int CHKSUM_LSB = 64;

    ////////////////////////////////////////////////////////////////////////////
    // Expected values
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [VERSION_MSB-VERSION_LSB:0] IP_VERSION = 4'd4;
    localparam logic [IHL_MSB-IHL_LSB:0]         IP_IHL     = 4'd5;

    // One's-complement sum of an intact header, checksum included
    localparam logic [WORD_BITS-1:0] SUM_ALL_ONES = 16'hFFFF;

endpackage

// ==== src/ipv4_status_encode.sv ====
/* Stage 3 of the header verifier: checks the folded sum and encodes one
   prioritized status per header together with the result strobe */

`timescale 1ns/100ps

module ipv4_status_encode
    import ipv4_hdr_pkg::*, chk_verify_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 s2_valid,
    input  logic [WORD_BITS-1:0] s2_sum,
    input  logic                 s2_version_bad,
    input  logic                 s2_ihl_bad,
    output logic                 result_valid,
    output chk_status_t          status,
    output logic                 checksum_ok
);

    logic        sum_ok;
    chk_status_t status_c;

    assign sum_ok = (s2_sum == SUM_ALL_ONES);

    // Priority: version, then IHL, then checksum
    always_comb begin
        if (s2_version_bad) begin
            status_c = HDR_BAD_VERSION;
        end else if (s2_ihl_bad) begin
            status_c = HDR_BAD_IHL;
        end else if (!sum_ok) begin
            status_c = HDR_BAD_CHECKSUM;
        end else begin
            status_c = HDR_GOOD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= s2_valid;
        end
    end

    // checksum_ok is reported even when a field check fails
    always_ff @(posedge clk) begin
        status      <= status_c;
        checksum_ok <= sum_ok;
    end

endmodule

// ==== src/ipv4_sum_fold.sv ====
/* Stage 2 of the header verifier: adds the partial sums and folds the carries
   back in to give the 16-bit one's-complement sum */

`timescale 1ns/100ps

module ipv4_sum_fold
    import ipv4_hdr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    s1_valid,
    input  logic [PARTIAL_BITS-1:0] s1_sum_hi,
    input  logic [PARTIAL_BITS-1:0] s1_sum_lo,
    input  logic                    s1_version_bad,
    input  logic                    s1_ihl_bad,
    output logic                    s2_valid,
    output logic [WORD_BITS-1:0]    s2_sum,
    output logic                    s2_version_bad,
    output logic                    s2_ihl_bad
);

    // Two 19-bit partials need at most 20 bits
    localparam int RAW_BITS = PARTIAL_BITS + 1;

    logic [RAW_BITS-1:0]  raw_sum;
    logic [WORD_BITS:0]   fold_once;
    logic [WORD_BITS-1:0] fold_twice;

    ////////////////////////////////////////////////////////////////////////////
    // End-around carry
    ////////////////////////////////////////////////////////////////////////////

    assign raw_sum = RAW_BITS'(s1_sum_hi) + RAW_BITS'(s1_sum_lo);

    // First fold leaves at most one carry bit
    assign fold_once = (WORD_BITS+1)'(raw_sum[WORD_BITS-1:0])
                     + (WORD_BITS+1)'(raw_sum[RAW_BITS-1:WORD_BITS]);

    // Second fold cannot overflow: a carry implies a small low half
    assign fold_twice = fold_once[WORD_BITS-1:0] + WORD_BITS'(fold_once[WORD_BITS]);

    ////////////////////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    // Flags ride along so they stay with their sum
    always_ff @(posedge clk) begin
        s2_sum         <= fold_twice;
        s2_version_bad <= s1_version_bad;
        s2_ihl_bad     <= s1_ihl_bad;
    end

endmodule

// ==== src/ipv4_word_sum.sv ====
/* Stage 1 of the header verifier: splits the header into words, registers two
   partial sums and flags a wrong version or IHL */

`timescale 1ns/100ps

module ipv4_word_sum
    import ipv4_hdr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    header_valid,
    input  logic [HDR_BITS-1:0]     header,
    output logic                    s1_valid,
    output logic [PARTIAL_BITS-1:0] s1_sum_hi,
    output logic [PARTIAL_BITS-1:0] s1_sum_lo,
    output logic                    s1_version_bad,
    output logic                    s1_ihl_bad
);

    localparam int HALF_WORDS = HDR_WORDS / 2;

    logic [WORD_BITS-1:0]    hdr_word [HDR_WORDS];
    logic [PARTIAL_BITS-1:0] sum_hi_c;
    logic [PARTIAL_BITS-1:0] sum_lo_c;

    ////////////////////////////////////////////////////////////////////////////
    // Word split and partial sums
    ////////////////////////////////////////////////////////////////////////////

    // Word 0 is the first two bytes on the wire
    always_comb begin
        for (int i = 0; i < HDR_WORDS; i++) begin
            hdr_word[i] = header[HDR_BITS-1-WORD_BITS*i -: WORD_BITS];
        end
    end

    // Plain binary sums; carries get folded in the next stage
    always_comb begin
        sum_hi_c = '0;
        sum_lo_c = '0;
        for (int i = 0; i < HALF_WORDS; i++) begin
            sum_hi_c = sum_hi_c + PARTIAL_BITS'(hdr_word[i]);
            sum_lo_c = sum_lo_c + PARTIAL_BITS'(hdr_word[i + HALF_WORDS]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= header_valid;
        end
    end

    // Qualified by s1_valid downstream
    always_ff @(posedge clk) begin
        s1_sum_hi      <= sum_hi_c;
        s1_sum_lo      <= sum_lo_c;
        s1_version_bad <= (header[VERSION_MSB:VERSION_LSB] != IP_VERSION);
        s1_ihl_bad     <= (header[IHL_MSB:IHL_LSB] != IP_IHL);
    end

endmodule

// ==== verif/ipv4_checksum_verify_props.sv ====
/* Concurrent checks on the verifier's result strobe and status.
   Bound to the top level from the testbench */

`timescale 1ns/100ps

module ipv4_checksum_verify_props
    import chk_verify_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        header_valid,
    input logic        result_valid,
    input chk_status_t status
);

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Strobe timing
    ////////////////////////////////////////////////////////////////////////////

    // One result per header, exactly VERIFY_LATENCY cycles later
    result_follows_header: assert property (
        @(posedge clk) disable iff (reset)
        result_valid == $past(header_valid, VERIFY_LATENCY)
    ) else begin
        $error("result_valid out of step with header_valid");
        fail_count++;
    end

    // Reset clears the output strobe
    quiet_in_reset: assert property (
        @(posedge clk) reset |=> !result_valid
    ) else begin
        $error("result_valid high during reset");
        fail_count++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Status legality
    ////////////////////////////////////////////////////////////////////////////

    status_known: assert property (
        @(posedge clk) disable iff (reset)
        result_valid |-> !$isunknown(status)
    ) else begin
        $error("status unknown while result_valid is high");
        fail_count++;
    end

endmodule

// ==== verif/ipv4_checksum_verify_tb.sv ====
/* Table-driven testbench for the IPv4 header verifier. Builds headers from an
   LFSR, predicts status and checksum_ok, and checks every result in order */

`timescale 1ns/100ps

module ipv4_checksum_verify_tb
    import ipv4_hdr_pkg::*, chk_verify_pkg::*;
;

    typedef enum {K_GOOD, K_BAD_SUM, K_BAD_VER, K_BAD_IHL, K_BAD_VER_GOOD_SUM} row_kind_t;

    localparam int NUM_ROWS        = 16;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 4 + 20;

    logic                clk;
    logic                reset;
    logic                header_valid;
    logic [HDR_BITS-1:0] header;
    logic                result_valid;
    chk_status_t         status;
    logic                checksum_ok;

    logic [15:0] lfsr_state = 16'd45184;
    chk_status_t exp_status_q [$];
    logic        exp_ok_q [$];

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table: header kind and idle cycles after it
    ////////////////////////////////////////////////////////////////////////////

    row_kind_t row_kind [NUM_ROWS] = '{
        K_GOOD, K_GOOD, K_BAD_SUM, K_BAD_VER, K_BAD_IHL, K_BAD_VER_GOOD_SUM,
        K_GOOD, K_BAD_SUM, K_BAD_SUM, K_BAD_IHL, K_GOOD, K_BAD_VER,
        K_GOOD, K_BAD_VER_GOOD_SUM, K_GOOD, K_BAD_SUM
    };
    int row_gap [NUM_ROWS] = '{0, 0, 0, 1, 0, 2, 3, 0, 0, 1, 0, 0, 2, 0, 1, 0};

    ipv4_checksum_verify u_dut (
        .clk          (clk),
        .reset        (reset),
        .header_valid (header_valid),
        .header       (header),
        .result_valid (result_valid),
        .status       (status),
        .checksum_ok  (checksum_ok)
    );

    bind ipv4_checksum_verify ipv4_checksum_verify_props u_props (
        .clk          (clk),
        .reset        (reset),
        .header_valid (header_valid),
        .result_valid (result_valid),
        .status       (status)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Galois form, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    // End-around carry applied after every word
    function automatic logic [15:0] ones_sum(input logic [HDR_BITS-1:0] h);
        logic [16:0] acc;
        acc = '0;
        for (int i = 0; i < HDR_WORDS; i++) begin
            acc = {1'b0, acc[15:0]} + {1'b0, h[HDR_BITS-1-16*i -: 16]};
            acc = {1'b0, acc[15:0]} + 17'(acc[16]);
        end
        return acc[15:0];
    endfunction

    task automatic build_header(input row_kind_t kind, output logic [HDR_BITS-1:0] h,
                                output chk_status_t exp_status, output logic exp_ok);
        logic [31:0] bits;
        logic [15:0] good_sum;
        logic [15:0] bad_sum;
        logic [3:0]  version;
        logic [3:0]  ihl;
        h = '0;
        for (int i = 0; i < HDR_WORDS; i++) begin
            take_bits(16, bits);
            h[HDR_BITS-1-16*i -: 16] = bits[15:0];
        end
        version = 4'd4;
        ihl = 4'd5;
        if (kind == K_BAD_VER || kind == K_BAD_VER_GOOD_SUM) begin
            take_bits(4, bits);
            version = (bits[3:0] == 4'd4) ? 4'd6 : bits[3:0];
        end
        if (kind == K_BAD_IHL) begin
            take_bits(4, bits);
            ihl = (bits[3:0] == 4'd5) ? 4'd7 : bits[3:0];
        end
        h[VERSION_MSB:VERSION_LSB] = version;
        h[IHL_MSB:IHL_LSB] = ihl;
        h[CHKSUM_MSB:CHKSUM_LSB] = '0;
        good_sum = ~ones_sum(h);
        h[CHKSUM_MSB:CHKSUM_LSB] = good_sum;
        if (kind == K_BAD_SUM || kind == K_BAD_VER) begin
            take_bits(16, bits);
            bad_sum = bits[15:0];
            if (bad_sum == good_sum) begin
                bad_sum = bad_sum + 16'd1;
            end
            h[CHKSUM_MSB:CHKSUM_LSB] = bad_sum;
        end
        exp_ok = (ones_sum(h) == 16'hFFFF);
        if (version != 4'd4) begin
            exp_status = HDR_BAD_VERSION;
        end else if (ihl != 4'd5) begin
            exp_status = HDR_BAD_IHL;
        end else if (!exp_ok) begin
            exp_status = HDR_BAD_CHECKSUM;
        end else begin
            exp_status = HDR_GOOD;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks and monitor
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_status(input chk_status_t actual, input chk_status_t expected);
        if (actual !== expected) begin
            $display("error: status got %h expected %h", actual, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error: %s got %h expected %h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // Falling edge keeps sampling clear of the registers' update
    always @(negedge clk) begin
        if (result_valid === 1'b1) begin
            if (exp_status_q.size() == 0) begin
                $display("A result strobe arrived with no header outstanding");
                $display("TB FAILED");
                $fatal(1);
            end else begin
                check_status(status, exp_status_q.pop_front());
                check_flag("checksum_ok", checksum_ok, exp_ok_q.pop_front());
            end
        end
    end

    always @(u_dut.u_props.fail_count) begin
        if (u_dut.u_props.fail_count != 0) begin
            $display("A bound assertion on the result strobe or status failed");
            $display("TB FAILED");
            $fatal(1);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: results stopped arriving before the table was done");
        $display("TB FAILED");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [HDR_BITS-1:0] hdr;
        chk_status_t         exp_status;
        logic                exp_ok;
        clk = 1'b0;
        reset = 1'b1;
        header_valid = 1'b0;
        header = '0;
        repeat (5) @(posedge clk);
        #5 reset = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            build_header(row_kind[r], hdr, exp_status, exp_ok);
            @(posedge clk);
            #5;
            header_valid = 1'b1;
            header = hdr;
            exp_status_q.push_back(exp_status);
            exp_ok_q.push_back(exp_ok);
            repeat (row_gap[r]) begin
                @(posedge clk);
                #5 header_valid = 1'b0;
            end
        end
        @(posedge clk);
        #5 header_valid = 1'b0;
        while (exp_status_q.size() != 0) begin
            @(negedge clk);
        end
        // Extra cycles catch any stray result
        repeat (VERIFY_LATENCY + 2) @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule
